/* rtl/mmu_pkg.sv */
package mmu_pkg;

    // TLB geometry
    localparam int TLB_ENTRIES   = 16;
    localparam int TLB_INDEX_W   = 4;

    // address and page fields
    localparam int VADDR_W       = 32;
    localparam int VPN2_W        = 19;
    localparam int ASID_W        = 8;
    localparam int PFN_W         = 20;
    localparam int PAGE_OFFSET_W = 12;
    localparam int PADDR_W       = PFN_W + PAGE_OFFSET_W;
    localparam int CACHE_ATTR_W  = 3;

    // EntryLo layout: pfn, attribute, dirty, valid, global
    localparam int ENTRYLO_W        = PFN_W + CACHE_ATTR_W + 3;
    localparam int ENTRYLO_D_BIT    = 2;
    localparam int ENTRYLO_V_BIT    = 1;
    localparam int ENTRYLO_G_BIT    = 0;

    // EntryHi and Index layout
    localparam int ENTRYHI_VPN2_LSB = 13;
    localparam int INDEX_P_BIT      = 31;

    // one search answer packed as hit, index, lo0, lo1
    localparam int SEARCH_W = 1 + TLB_INDEX_W + 2 * ENTRYLO_W;

    // CP0 register numbers
    localparam int CP0_DATA_W = 32;
    localparam int CP0_SEL_W  = 5;
    localparam logic [CP0_SEL_W-1:0] CP0_SEL_INDEX    = 5'd0;
    localparam logic [CP0_SEL_W-1:0] CP0_SEL_RANDOM   = 5'd1;
    localparam logic [CP0_SEL_W-1:0] CP0_SEL_ENTRYLO0 = 5'd2;
    localparam logic [CP0_SEL_W-1:0] CP0_SEL_ENTRYLO1 = 5'd3;
    localparam logic [CP0_SEL_W-1:0] CP0_SEL_ENTRYHI  = 5'd10;

endpackage

/* rtl/tlb_write_if.sv */
interface tlb_write_if;
    import mmu_pkg::*;

    // strobe and slot, from the instruction control
    logic                   we;
    logic [TLB_INDEX_W-1:0] windex;

    // entry contents, straight from the CP0 registers
    logic [CP0_DATA_W-1:0]  entryhi;
    logic [ENTRYLO_W-1:0]   entrylo0;
    logic [ENTRYLO_W-1:0]   entrylo1;

    modport ctrl (
        output we,
        output windex
    );

    modport regs (
        output entryhi,
        output entrylo0,
        output entrylo1
    );

    modport array (
        input we,
        input windex,
        input entryhi,
        input entrylo0,
        input entrylo1
    );

endinterface

/* rtl/tlb_search_if.sv */
interface tlb_search_if;
    import mmu_pkg::*;

    // request side
    logic [VPN2_W-1:0]      vpn2;
    logic [ASID_W-1:0]      asid;

    // answer, combinational from the entry array
    logic                   hit;
    logic [TLB_INDEX_W-1:0] index;
    logic [ENTRYLO_W-1:0]   lo0;
    logic [ENTRYLO_W-1:0]   lo1;

    modport requester (
        output vpn2,
        output asid,
        input  hit,
        input  index,
        input  lo0,
        input  lo1
    );

    modport array (
        input  vpn2,
        input  asid,
        output hit,
        output index,
        output lo0,
        output lo1
    );

endinterface

/* rtl/tlb_ctrl.sv */
module tlb_ctrl (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            tlbwi,
    input  logic                            tlbwr,
    input  logic                            tlbp,
    input  logic [mmu_pkg::TLB_INDEX_W-1:0] index_field,
    output logic                            probe_capture,
    output logic [mmu_pkg::TLB_INDEX_W-1:0] random_value,
    tlb_write_if.ctrl                       wr
);
    import mmu_pkg::*;

    // Random counts down every cycle and wraps from 0 to the top entry
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            random_value <= TLB_INDEX_W'(TLB_ENTRIES - 1);
        end else begin
            random_value <= random_value - 1'b1;
        end
    end

    // tlbwr takes the slot from Random before it moves
    assign wr.we     = tlbwi | tlbwr;
    assign wr.windex = tlbwr ? random_value : index_field;

    // Index latches the probe result at the same edge
    assign probe_capture = tlbp;

endmodule

/* rtl/cp0_mmu_regs.sv */
module cp0_mmu_regs (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            cp0_wen,
    input  logic [mmu_pkg::CP0_SEL_W-1:0]   cp0_sel,
    input  logic [mmu_pkg::CP0_DATA_W-1:0]  cp0_wdata,
    output logic [mmu_pkg::CP0_DATA_W-1:0]  cp0_rdata,
    input  logic                            probe_capture,
    input  logic [mmu_pkg::TLB_INDEX_W-1:0] random_value,
    output logic [mmu_pkg::TLB_INDEX_W-1:0] index_field,
    output logic [mmu_pkg::ASID_W-1:0]      asid,
    tlb_write_if.regs                       wr,
    tlb_search_if.requester                 probe
);
    import mmu_pkg::*;

    logic                   index_p;
    logic [TLB_INDEX_W-1:0] index_val;
    logic [VPN2_W-1:0]      hi_vpn2;
    logic [ASID_W-1:0]      hi_asid;
    logic [ENTRYLO_W-1:0]   lo0;
    logic [ENTRYLO_W-1:0]   lo1;
    logic [CP0_DATA_W-1:0]  entryhi_word;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            index_p   <= 1'b0;
            index_val <= '0;
            hi_vpn2   <= '0;
            hi_asid   <= '0;
            lo0       <= '0;
            lo1       <= '0;
        end else if (cp0_wen) begin
            // only the defined fields are kept, Random is read only
            case (cp0_sel)
                CP0_SEL_INDEX: begin
                    index_p   <= cp0_wdata[INDEX_P_BIT];
                    index_val <= cp0_wdata[TLB_INDEX_W-1:0];
                end
                CP0_SEL_ENTRYHI: begin
                    hi_vpn2 <= cp0_wdata[ENTRYHI_VPN2_LSB +: VPN2_W];
                    hi_asid <= cp0_wdata[ASID_W-1:0];
                end
                CP0_SEL_ENTRYLO0: lo0 <= cp0_wdata[ENTRYLO_W-1:0];
                CP0_SEL_ENTRYLO1: lo1 <= cp0_wdata[ENTRYLO_W-1:0];
                default: ;
            endcase
        end else if (probe_capture) begin
            // a failed probe leaves the index field alone
            index_p <= ~probe.hit;
            if (probe.hit) begin
                index_val <= probe.index;
            end
        end
    end

    assign entryhi_word = {hi_vpn2, {(ENTRYHI_VPN2_LSB - ASID_W){1'b0}}, hi_asid};

    always_comb begin
        case (cp0_sel)
            CP0_SEL_INDEX:
                cp0_rdata = {index_p, {(CP0_DATA_W - 1 - TLB_INDEX_W){1'b0}}, index_val};
            CP0_SEL_RANDOM:
                cp0_rdata = {{(CP0_DATA_W - TLB_INDEX_W){1'b0}}, random_value};
            CP0_SEL_ENTRYLO0: cp0_rdata = {{(CP0_DATA_W - ENTRYLO_W){1'b0}}, lo0};
            CP0_SEL_ENTRYLO1: cp0_rdata = {{(CP0_DATA_W - ENTRYLO_W){1'b0}}, lo1};
            CP0_SEL_ENTRYHI:  cp0_rdata = entryhi_word;
            default:          cp0_rdata = '0;
        endcase
    end

    // entry source for tlbwi and tlbwr
    assign wr.entryhi  = entryhi_word;
    assign wr.entrylo0 = lo0;
    assign wr.entrylo1 = lo1;

    // probe uses the current EntryHi
    assign probe.vpn2 = hi_vpn2;
    assign probe.asid = hi_asid;

    assign index_field = index_val;
    assign asid        = hi_asid;

endmodule

/* rtl/tlb_entry_array.sv */
module tlb_entry_array (
    input  logic        aclk,
    input  logic        rst_n,
    tlb_write_if.array  wr,
    tlb_search_if.array ifetch,
    tlb_search_if.array data,
    tlb_search_if.array probe
);
    import mmu_pkg::*;

    // per-entry storage with the global bit kept once
    logic [TLB_ENTRIES-1:0] ent_used;
    logic [TLB_ENTRIES-1:0] ent_g;
    logic [VPN2_W-1:0]      ent_vpn2 [TLB_ENTRIES];
    logic [ASID_W-1:0]      ent_asid [TLB_ENTRIES];
    logic [ENTRYLO_W-2:0]   ent_lo0  [TLB_ENTRIES];
    logic [ENTRYLO_W-2:0]   ent_lo1  [TLB_ENTRIES];

    // empty slots never match, so a cleared array misses everywhere
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            ent_used <= '0;
        end else if (wr.we) begin
            ent_used[wr.windex] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr.we) begin
            ent_vpn2[wr.windex] <= wr.entryhi[ENTRYHI_VPN2_LSB +: VPN2_W];
            ent_asid[wr.windex] <= wr.entryhi[ASID_W-1:0];
            ent_g[wr.windex]    <= wr.entrylo0[ENTRYLO_G_BIT] & wr.entrylo1[ENTRYLO_G_BIT];
            ent_lo0[wr.windex]  <= wr.entrylo0[ENTRYLO_W-1:1];
            ent_lo1[wr.windex]  <= wr.entrylo1[ENTRYLO_W-1:1];
        end
    end

    // at most one entry matches, so the fields are simply or-ed together
    function automatic logic [SEARCH_W-1:0] search(
        input logic [VPN2_W-1:0] vpn2,
        input logic [ASID_W-1:0] asid
    );
        logic                   hit;
        logic [TLB_INDEX_W-1:0] idx;
        logic [ENTRYLO_W-1:0]   lo0;
        logic [ENTRYLO_W-1:0]   lo1;
        hit = 1'b0;
        idx = '0;
        lo0 = '0;
        lo1 = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_used[i] && ent_vpn2[i] == vpn2 && (ent_g[i] || ent_asid[i] == asid)) begin
                hit = 1'b1;
                idx = idx | TLB_INDEX_W'(i);
                lo0 = lo0 | {ent_lo0[i], ent_g[i]};
                lo1 = lo1 | {ent_lo1[i], ent_g[i]};
            end
        end
        return {hit, idx, lo0, lo1};
    endfunction

    // the searches also follow entry writes, not only the request
    always_comb begin
        {ifetch.hit, ifetch.index, ifetch.lo0, ifetch.lo1} = search(ifetch.vpn2, ifetch.asid);
    end

    always_comb begin
        {data.hit, data.index, data.lo0, data.lo1} = search(data.vpn2, data.asid);
    end

    always_comb begin
        {probe.hit, probe.index, probe.lo0, probe.lo1} = search(probe.vpn2, probe.asid);
    end

endmodule

/* rtl/tlb_translate.sv */
module tlb_translate (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic [mmu_pkg::VADDR_W-1:0]   vaddr,
    input  logic [mmu_pkg::ASID_W-1:0]    asid,
    output logic                          done,
    output logic [mmu_pkg::PADDR_W-1:0]   paddr,
    output logic                          miss,
    output logic                          invalid,
    output logic                          dirty,
    tlb_search_if.requester               lookup
);
    import mmu_pkg::*;

    logic [ENTRYLO_W-1:0] page_lo;

    assign lookup.vpn2 = vaddr[VADDR_W-1 -: VPN2_W];
    assign lookup.asid = asid;

    // odd page when the bit just above the offset is set
    assign page_lo = vaddr[PAGE_OFFSET_W] ? lookup.lo1 : lookup.lo0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= req;
        end
    end

    // result held until the next request
    always_ff @(posedge aclk) begin
        if (req) begin
            miss <= ~lookup.hit;
            if (lookup.hit) begin
                paddr   <= {page_lo[ENTRYLO_W-1 -: PFN_W], vaddr[PAGE_OFFSET_W-1:0]};
                invalid <= ~page_lo[ENTRYLO_V_BIT];
                dirty   <= page_lo[ENTRYLO_D_BIT];
            end else begin
                paddr   <= '0;
                invalid <= 1'b0;
                dirty   <= 1'b0;
            end
        end
    end

endmodule

/* rtl/mmu_top.sv */
module mmu_top (
    input  logic                           aclk,
    input  logic                           rst_n,
    // instruction fetch lookup
    input  logic                           i_req,
    input  logic [mmu_pkg::VADDR_W-1:0]    i_vaddr,
    output logic                           i_done,
    output logic [mmu_pkg::PADDR_W-1:0]    i_paddr,
    output logic                           i_miss,
    output logic                           i_invalid,
    // data lookup
    input  logic                           d_req,
    input  logic [mmu_pkg::VADDR_W-1:0]    d_vaddr,
    output logic                           d_done,
    output logic [mmu_pkg::PADDR_W-1:0]    d_paddr,
    output logic                           d_miss,
    output logic                           d_invalid,
    output logic                           d_dirty,
    // software register access
    input  logic                           cp0_wen,
    input  logic [mmu_pkg::CP0_SEL_W-1:0]  cp0_sel,
    input  logic [mmu_pkg::CP0_DATA_W-1:0] cp0_wdata,
    output logic [mmu_pkg::CP0_DATA_W-1:0] cp0_rdata,
    // TLB instructions
    input  logic                           tlbwi,
    input  logic                           tlbwr,
    input  logic                           tlbp
);
    import mmu_pkg::*;

    logic                   probe_capture;
    logic [TLB_INDEX_W-1:0] random_value;
    logic [TLB_INDEX_W-1:0] index_field;
    logic [ASID_W-1:0]      cur_asid;

    tlb_write_if  tlb_wr ();
    tlb_search_if ifetch_search ();
    tlb_search_if data_search ();
    tlb_search_if probe_search ();

    tlb_ctrl u_tlb_ctrl (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .tlbwi         (tlbwi),
        .tlbwr         (tlbwr),
        .tlbp          (tlbp),
        .index_field   (index_field),
        .probe_capture (probe_capture),
        .random_value  (random_value),
        .wr            (tlb_wr.ctrl)
    );

    cp0_mmu_regs u_cp0_mmu_regs (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cp0_wen       (cp0_wen),
        .cp0_sel       (cp0_sel),
        .cp0_wdata     (cp0_wdata),
        .cp0_rdata     (cp0_rdata),
        .probe_capture (probe_capture),
        .random_value  (random_value),
        .index_field   (index_field),
        .asid          (cur_asid),
        .wr            (tlb_wr.regs),
        .probe         (probe_search.requester)
    );

    tlb_entry_array u_tlb_entry_array (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .wr     (tlb_wr.array),
        .ifetch (ifetch_search.array),
        .data   (data_search.array),
        .probe  (probe_search.array)
    );

    tlb_translate ifetch_xlat (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .req     (i_req),
        .vaddr   (i_vaddr),
        .asid    (cur_asid),
        .done    (i_done),
        .paddr   (i_paddr),
        .miss    (i_miss),
        .invalid (i_invalid),
        .dirty   (),
        .lookup  (ifetch_search.requester)
    );

    tlb_translate data_xlat (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .req     (d_req),
        .vaddr   (d_vaddr),
        .asid    (cur_asid),
        .done    (d_done),
        .paddr   (d_paddr),
        .miss    (d_miss),
        .invalid (d_invalid),
        .dirty   (d_dirty),
        .lookup  (data_search.requester)
    );

endmodule

/* dv/mmu_properties.sv */
module mmu_properties (
    input logic aclk,
    input logic rst_n,
    input logic i_req,
    input logic i_done,
    input logic d_req,
    input logic d_done,
    input logic tlbwi,
    input logic tlbwr,
    input logic tlbp
);

    // the TLB instructions never overlap
    tlb_op_exclusive: assert property (
        @(posedge aclk) disable iff (!rst_n) $onehot0({tlbwi, tlbwr, tlbp})
    ) else $error("more than one TLB instruction in one cycle");

    i_done_follows_req: assert property (
        @(posedge aclk) disable iff (!rst_n) i_done == $past(i_req)
    ) else $error("i_done does not follow i_req by one cycle");

    d_done_follows_req: assert property (
        @(posedge aclk) disable iff (!rst_n) d_done == $past(d_req)
    ) else $error("d_done does not follow d_req by one cycle");

    // a reset edge leaves both ports idle
    done_low_after_reset: assert property (
        @(posedge aclk) !rst_n |=> !i_done && !d_done
    ) else $error("done output high after reset");

endmodule

bind mmu_top mmu_properties u_mmu_properties (
    .aclk   (aclk),
    .rst_n  (rst_n),
    .i_req  (i_req),
    .i_done (i_done),
    .d_req  (d_req),
    .d_done (d_done),
    .tlbwi  (tlbwi),
    .tlbwr  (tlbwr),
    .tlbp   (tlbp)
);

/* dv/mmu_tb.sv */
module mmu_tb;
    import mmu_pkg::*;

    parameter int SEED = 12455;

    // phase lengths in cycles to size the watchdog
    localparam int CP0_OPS      = 40;
    localparam int MAP_TRAFFIC  = 200;
    localparam int ASID_TRAFFIC = 100;
    localparam int WR_TRAFFIC   = 100;
    localparam int TEST_CYCLES  = 2 + CP0_OPS + 8 * 5 + MAP_TRAFFIC + 1 + ASID_TRAFFIC
                                  + 2 * 4 + 4 * 6 + 1 + WR_TRAFFIC + 1;
    localparam int MARGIN       = 200;

    logic        aclk;
    logic        rst_n;
    logic        i_req;
    logic [31:0] i_vaddr;
    logic        i_done;
    logic [31:0] i_paddr;
    logic        i_miss;
    logic        i_invalid;
    logic        d_req;
    logic [31:0] d_vaddr;
    logic        d_done;
    logic [31:0] d_paddr;
    logic        d_miss;
    logic        d_invalid;
    logic        d_dirty;
    logic        cp0_wen;
    logic [4:0]  cp0_sel;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        tlbwi;
    logic        tlbwr;
    logic        tlbp;
    integer      seed;

    // reference model of the entries and the CP0 registers
    logic [TLB_ENTRIES-1:0] m_used;
    logic [TLB_ENTRIES-1:0] m_g;
    logic [VPN2_W-1:0]      m_vpn2 [TLB_ENTRIES];
    logic [ASID_W-1:0]      m_asid [TLB_ENTRIES];
    logic [ENTRYLO_W-1:0]   m_lo0 [TLB_ENTRIES];
    logic [ENTRYLO_W-1:0]   m_lo1 [TLB_ENTRIES];
    logic                   m_p;
    logic [3:0]             m_index;
    logic [VPN2_W-1:0]      m_hi_vpn2;
    logic [ASID_W-1:0]      m_hi_asid;
    logic [ENTRYLO_W-1:0]   m_elo0;
    logic [ENTRYLO_W-1:0]   m_elo1;
    logic [3:0]             m_random;

    // expected results packed as miss, invalid, dirty and paddr
    logic        exp_i_done;
    logic        exp_d_done;
    logic [34:0] exp_i;
    logic [34:0] exp_d;

    mmu_top dut (.*);

    always #5 aclk = ~aclk;

    // matching entry for a page pair under an asid or -1 when none
    function automatic int find_entry(input logic [VPN2_W-1:0] vpn2,
                                      input logic [ASID_W-1:0] asid);
        int found;
        found = -1;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (m_used[i] && m_vpn2[i] == vpn2 && (m_g[i] || m_asid[i] == asid)) begin
                found = i;
            end
        end
        return found;
    endfunction

    function automatic logic [34:0] ref_translate(input logic [31:0] vaddr,
                                                  input logic [ASID_W-1:0] asid);
        int                   e;
        logic [ENTRYLO_W-1:0] lo;
        e = find_entry(vaddr[31:13], asid);
        if (e < 0) begin
            return {1'b1, 2'b00, 32'h0};
        end
        // odd page of the pair when bit 12 is set
        lo = vaddr[12] ? m_lo1[e] : m_lo0[e];
        return {1'b0, ~lo[1], lo[2], lo[25:6], vaddr[11:0]};
    endfunction

    function automatic logic [31:0] ref_cp0_read(input logic [4:0] sel);
        case (sel)
            CP0_SEL_INDEX:    return {m_p, 27'h0, m_index};
            CP0_SEL_RANDOM:   return {28'h0, m_random};
            CP0_SEL_ENTRYLO0: return {6'h0, m_elo0};
            CP0_SEL_ENTRYLO1: return {6'h0, m_elo1};
            CP0_SEL_ENTRYHI:  return {m_hi_vpn2, 5'h0, m_hi_asid};
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic [4:0] sel_of(input int k);
        case (k)
            0:       return CP0_SEL_INDEX;
            1:       return CP0_SEL_RANDOM;
            2:       return CP0_SEL_ENTRYLO0;
            3:       return CP0_SEL_ENTRYLO1;
            default: return CP0_SEL_ENTRYHI;
        endcase
    endfunction

    task automatic model_write_entry(input logic [3:0] slot);
        m_used[slot] = 1'b1;
        m_vpn2[slot] = m_hi_vpn2;
        m_asid[slot] = m_hi_asid;
        m_g[slot]    = m_elo0[0] & m_elo1[0];
        m_lo0[slot]  = m_elo0;
        m_lo1[slot]  = m_elo1;
    endtask

    task automatic model_cp0_write(input logic [4:0] sel, input logic [31:0] data);
        case (sel)
            CP0_SEL_INDEX: begin
                m_p     = data[31];
                m_index = data[3:0];
            end
            CP0_SEL_ENTRYHI: begin
                m_hi_vpn2 = data[31:13];
                m_hi_asid = data[7:0];
            end
            CP0_SEL_ENTRYLO0: m_elo0 = data[25:0];
            CP0_SEL_ENTRYLO1: m_elo1 = data[25:0];
            default: ;
        endcase
    endtask

    // state before the edge feeds the model's lookups and writes
    always @(posedge aclk) begin
        int e;
        if (!rst_n) begin
            m_used     = '0;
            m_p        = 1'b0;
            m_index    = '0;
            m_hi_vpn2  = '0;
            m_hi_asid  = '0;
            m_elo0     = '0;
            m_elo1     = '0;
            m_random   = 4'd15;
            exp_i_done = 1'b0;
            exp_d_done = 1'b0;
        end else begin
            exp_i_done = i_req;
            exp_d_done = d_req;
            if (i_req) begin
                exp_i = ref_translate(i_vaddr, m_hi_asid);
            end
            if (d_req) begin
                exp_d = ref_translate(d_vaddr, m_hi_asid);
            end
            if (tlbwi || tlbwr) begin
                model_write_entry(tlbwr ? m_random : m_index);
            end
            if (tlbp) begin
                e = find_entry(m_hi_vpn2, m_hi_asid);
                m_p = (e < 0);
                if (e >= 0) begin
                    m_index = e[3:0];
                end
            end
            if (cp0_wen) begin
                model_cp0_write(cp0_sel, cp0_wdata);
            end
            m_random = m_random - 4'd1;
        end
    end

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge aclk) begin
        if (rst_n) begin
            check_value("i_done", 32'(i_done), 32'(exp_i_done));
            check_value("d_done", 32'(d_done), 32'(exp_d_done));
            if (exp_i_done) begin
                check_value("i_paddr", i_paddr, exp_i[31:0]);
                check_value("i_miss", 32'(i_miss), 32'(exp_i[34]));
                check_value("i_invalid", 32'(i_invalid), 32'(exp_i[33]));
            end
            if (exp_d_done) begin
                check_value("d_paddr", d_paddr, exp_d[31:0]);
                check_value("d_miss", 32'(d_miss), 32'(exp_d[34]));
                check_value("d_invalid", 32'(d_invalid), 32'(exp_d[33]));
                check_value("d_dirty", 32'(d_dirty), 32'(exp_d[32]));
            end
            check_value("cp0_rdata", cp0_rdata, ref_cp0_read(cp0_sel));
        end
    end

    task automatic tick();
        @(posedge aclk);
        #1;
    endtask

    task automatic cp0_write(input logic [4:0] sel, input logic [31:0] data);
        cp0_wen   = 1'b1;
        cp0_sel   = sel;
        cp0_wdata = data;
        tick();
        cp0_wen   = 1'b0;
    endtask

    task automatic run_tlb_op(input logic wi, input logic wr, input logic p);
        tlbwi = wi;
        tlbwr = wr;
        tlbp  = p;
        tick();
        tlbwi = 1'b0;
        tlbwr = 1'b0;
        tlbp  = 1'b0;
    endtask

    task automatic read_index_after(input logic [31:0] expected);
        cp0_sel = CP0_SEL_INDEX;
        #2;
        check_value("cp0_rdata", cp0_rdata, expected);
        tick();
    endtask

    // random EntryLo words where the entry is global only when both halves carry it
    task automatic load_entry_regs(input logic [VPN2_W-1:0] vpn2,
                                   input logic [ASID_W-1:0] asid, input logic glob);
        logic [31:0] lo0;
        logic [31:0] lo1;
        lo0 = $random(seed);
        lo1 = $random(seed);
        if (glob) begin
            lo0[0] = 1'b1;
            lo1[0] = 1'b1;
        end else begin
            // at most one half carries the bit
            lo1[0] = lo1[0] & ~lo0[0];
        end
        cp0_write(CP0_SEL_ENTRYHI, {vpn2, 5'h0, asid});
        cp0_write(CP0_SEL_ENTRYLO0, lo0);
        cp0_write(CP0_SEL_ENTRYLO1, lo1);
    endtask

    // both ports busy on pages base to base+15 with only the low half mapped
    task automatic run_traffic(input int cycles, input logic [VPN2_W-1:0] base);
        logic [31:0] r;
        repeat (cycles) begin
            i_req   = 1'b1;
            d_req   = 1'b1;
            r       = $random(seed);
            i_vaddr = {base + VPN2_W'(r[3:0]), r[16:4]};
            cp0_sel = sel_of(int'(r[31:29]) % 5);
            r       = $random(seed);
            d_vaddr = {base + VPN2_W'(r[3:0]), r[16:4]};
            tick();
        end
        i_req = 1'b0;
        d_req = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        seed      = SEED;
        aclk      = 1'b0;
        rst_n     = 1'b0;
        i_req     = 1'b0;
        i_vaddr   = '0;
        d_req     = 1'b0;
        d_vaddr   = '0;
        cp0_wen   = 1'b0;
        cp0_sel   = '0;
        cp0_wdata = '0;
        tlbwi     = 1'b0;
        tlbwr     = 1'b0;
        tlbp      = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        // register writes read back in the following cycle
        repeat (CP0_OPS) begin
            r = $random(seed);
            cp0_write(sel_of(int'($unsigned(r) % 5)), $random(seed));
        end

        // eight entries by tlbwi with every third one global
        for (int k = 0; k < 8; k++) begin
            load_entry_regs(VPN2_W'(19'h100 + k), 8'h05, k % 3 == 0);
            cp0_write(CP0_SEL_INDEX, k);
            run_tlb_op(1'b1, 1'b0, 1'b0);
        end
        run_traffic(MAP_TRAFFIC, 19'h100);

        // another asid leaves only the global entries mapped
        cp0_write(CP0_SEL_ENTRYHI, {19'h0, 5'h0, 8'h06});
        run_traffic(ASID_TRAFFIC, 19'h100);

        // probe a present page and then one nobody mapped
        cp0_write(CP0_SEL_ENTRYHI, {19'h102, 5'h0, 8'h05});
        run_tlb_op(1'b0, 1'b0, 1'b1);
        read_index_after(32'h0000_0002);
        cp0_write(CP0_SEL_ENTRYHI, {19'h7ffff, 5'h0, 8'h05});
        run_tlb_op(1'b0, 1'b0, 1'b1);
        read_index_after(32'h8000_0002);

        // tlbwr lands on Random and is confirmed by a probe and by traffic
        for (int j = 0; j < 4; j++) begin
            load_entry_regs(VPN2_W'(19'h200 + j), 8'h05, 1'b0);
            run_tlb_op(1'b0, 1'b1, 1'b0);
            run_tlb_op(1'b0, 1'b0, 1'b1);
            cp0_sel = CP0_SEL_INDEX;
            tick();
        end
        cp0_write(CP0_SEL_ENTRYHI, {19'h0, 5'h0, 8'h05});
        run_traffic(WR_TRAFFIC, 19'h200);
        tick();

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 10);
        $display("watchdog expired before the tests completed");
        stop_on_error();
    end

endmodule

/* src.f */
rtl/mmu_pkg.sv
rtl/tlb_write_if.sv
rtl/tlb_search_if.sv
rtl/tlb_ctrl.sv
rtl/cp0_mmu_regs.sv
rtl/tlb_entry_array.sv
rtl/tlb_translate.sv
rtl/mmu_top.sv
dv/mmu_properties.sv
dv/mmu_tb.sv

/* Makefile */
TOP       ?= mmu_tb
SEED      ?= 12455
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f src.f --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f src.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)
